// ==== rtl/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// issue queue entries
`define ISSUE_QUEUE_DEPTH 16

// architectural register file
`define REG_COUNT  32
`define REG_ADDR_W 5

`define DATA_W 32
`define IMM_W  16

`endif

// ==== rtl/issue_pkg.sv ====
`include "issue_consts.svh"

package issue_pkg;

    // decoded opcode classes seen by the issue stage
    typedef enum logic [3:0] {
        ALU    = 4'd0,
        LOAD   = 4'd1,
        STORE  = 4'd2,
        BRANCH = 4'd3,
        MULT   = 4'd4,
        MULTU  = 4'd5,
        DIV    = 4'd6,
        DIVU   = 4'd7,
        MFHI   = 4'd8,
        MFLO   = 4'd9,
        MFC0   = 4'd10,
        MTC0   = 4'd11
    } issue_op_t;

    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // register values and pcs
    typedef logic [`DATA_W-1:0] data_t;

    typedef logic [`IMM_W-1:0] imm_t;

    // wraps naturally at the queue depth
    typedef logic [$clog2(`ISSUE_QUEUE_DEPTH)-1:0] queue_ptr_t;

    // one extra bit so a full queue is distinct from an empty one
    typedef logic [$clog2(`ISSUE_QUEUE_DEPTH):0] queue_cnt_t;

    // hi/lo unit users, only one of these may issue per cycle
    function automatic logic is_muldiv(input issue_op_t op);
        logic hit;
        hit = (op == MULT) || (op == MULTU) || (op == DIV) || (op == DIVU);
        return hit;
    endfunction

endpackage

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           wb_en,
    input  issue_pkg::reg_addr_t wb_addr [1:0],
    input  issue_pkg::data_t     wb_data [1:0],
    input  issue_pkg::reg_addr_t rd_addr [3:0],
    output issue_pkg::data_t     rd_data [3:0]
);

    import issue_pkg::*;

    data_t regs [`REG_COUNT-1:0];

    // port 0 is applied first so port 1 overrides it on a shared address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (wb_en[p] && (wb_addr[p] != '0)) begin
                    regs[wb_addr[p]] <= wb_data[p];
                end
            end
        end
    end

    // asynchronous reads, no write-through to the same cycle
    for (genvar p = 0; p < 4; p++) begin : g_read
        assign rd_data[p] = (rd_addr[p] == '0) ? '0 : regs[rd_addr[p]];
    end

endmodule

// ==== rtl/pair_check.sv ====
`timescale 1ns/1ps

module pair_check (
    input  logic                 old_regwrite,
    input  issue_pkg::reg_addr_t old_rdst,
    input  issue_pkg::issue_op_t old_op,
    input  issue_pkg::reg_addr_t young_ra1,
    input  issue_pkg::reg_addr_t young_ra2,
    input  issue_pkg::issue_op_t young_op,
    output logic                 pair_ok
);

    import issue_pkg::*;

    logic dst_live;
    logic raw_hazard;
    logic muldiv_clash;
    logic cp0_clash;

    // writes to r0 are dropped, so they never create a dependency
    assign dst_live = old_regwrite && (old_rdst != '0);

    assign raw_hazard = dst_live && ((old_rdst == young_ra1) || (old_rdst == young_ra2));

    // single hi/lo unit
    assign muldiv_clash = is_muldiv(old_op) && is_muldiv(young_op);

    // cp0 accepts one write per cycle
    assign cp0_clash = (old_op == MTC0) && (young_op == MTC0);

    assign pair_ok = !(raw_hazard || muldiv_clash || cp0_clash);

endmodule

// ==== rtl/issue_queue.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic [1:0]           dec_valid,
    input  issue_pkg::issue_op_t dec_op [1:0],
    input  issue_pkg::reg_addr_t dec_rdst [1:0],
    input  logic [1:0]           dec_regwrite,
    input  issue_pkg::reg_addr_t dec_ra1 [1:0],
    input  issue_pkg::reg_addr_t dec_ra2 [1:0],
    input  issue_pkg::imm_t      dec_imm [1:0],
    input  issue_pkg::data_t     dec_pc [1:0],
    input  logic [1:0]           operand_ready,
    output logic                 stall,
    output logic [1:0]           cand_valid,
    output issue_pkg::issue_op_t cand_op [1:0],
    output issue_pkg::reg_addr_t cand_rdst [1:0],
    output logic [1:0]           cand_regwrite,
    output issue_pkg::reg_addr_t cand_ra1 [1:0],
    output issue_pkg::reg_addr_t cand_ra2 [1:0],
    output issue_pkg::imm_t      cand_imm [1:0],
    output issue_pkg::data_t     cand_pc [1:0],
    output logic [1:0]           issue_en
);

    import issue_pkg::*;

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;

    issue_op_t        q_op [DEPTH-1:0];
    reg_addr_t        q_rdst [DEPTH-1:0];
    logic [DEPTH-1:0] q_regwrite;
    reg_addr_t        q_ra1 [DEPTH-1:0];
    reg_addr_t        q_ra2 [DEPTH-1:0];
    imm_t             q_imm [DEPTH-1:0];
    data_t            q_pc [DEPTH-1:0];

    queue_ptr_t head;
    queue_ptr_t tail;
    queue_ptr_t head_nxt;
    queue_cnt_t count;
    queue_cnt_t count_next;

    logic [1:0] in_valid;
    logic [1:0] from_q;
    logic [1:0] from_dec;
    logic [1:0] dec_idx;
    queue_ptr_t q_idx [1:0];
    logic       pair_ok;
    logic [1:0] dec_issued;
    logic [1:0] enq;
    logic [1:0] q_take;
    logic [1:0] n_enq;
    queue_ptr_t wr_ptr [1:0];

    // decode holds its pair while stalled, so that pair is not new
    assign in_valid = dec_valid & {2{~stall}};
    assign head_nxt = head + queue_ptr_t'(1);

    // queue entries are older than anything arriving from decode
    always_comb begin
        from_q[1]   = (count != '0);
        q_idx[1]    = head;
        from_dec[1] = (count == '0) && in_valid[1];
        dec_idx[1]  = 1'b1;
        from_q[0]   = (count >= queue_cnt_t'(2));
        q_idx[0]    = head_nxt;
        if (count == queue_cnt_t'(1)) begin
            from_dec[0] = in_valid[1];
            dec_idx[0]  = 1'b1;
        end else begin
            from_dec[0] = (count == '0) && in_valid[0];
            dec_idx[0]  = 1'b0;
        end
    end

    // candidate fields read as zero when there is no candidate
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            cand_valid[k]    = from_q[k] || from_dec[k];
            cand_op[k]       = ALU;
            cand_rdst[k]     = '0;
            cand_regwrite[k] = 1'b0;
            cand_ra1[k]      = '0;
            cand_ra2[k]      = '0;
            cand_imm[k]      = '0;
            cand_pc[k]       = '0;
            if (from_q[k]) begin
                cand_op[k]       = q_op[q_idx[k]];
                cand_rdst[k]     = q_rdst[q_idx[k]];
                cand_regwrite[k] = q_regwrite[q_idx[k]];
                cand_ra1[k]      = q_ra1[q_idx[k]];
                cand_ra2[k]      = q_ra2[q_idx[k]];
                cand_imm[k]      = q_imm[q_idx[k]];
                cand_pc[k]       = q_pc[q_idx[k]];
            end else if (from_dec[k]) begin
                cand_op[k]       = dec_op[dec_idx[k]];
                cand_rdst[k]     = dec_rdst[dec_idx[k]];
                cand_regwrite[k] = dec_regwrite[dec_idx[k]];
                cand_ra1[k]      = dec_ra1[dec_idx[k]];
                cand_ra2[k]      = dec_ra2[dec_idx[k]];
                cand_imm[k]      = dec_imm[dec_idx[k]];
                cand_pc[k]       = dec_pc[dec_idx[k]];
            end
        end
    end

    pair_check u_pair_check (
        .old_regwrite (cand_regwrite[1]),
        .old_rdst     (cand_rdst[1]),
        .old_op       (cand_op[1]),
        .young_ra1    (cand_ra1[0]),
        .young_ra2    (cand_ra2[0]),
        .young_op     (cand_op[0]),
        .pair_ok      (pair_ok)
    );

    // in order, the younger never passes the older
    assign issue_en[1] = cand_valid[1] && operand_ready[1];
    assign issue_en[0] = cand_valid[0] && issue_en[1] && operand_ready[0] && pair_ok;

    // account issued candidates against their source
    assign q_take = {1'b0, from_q[1] && issue_en[1]} + {1'b0, from_q[0] && issue_en[0]};
    assign dec_issued[1] = (from_dec[1] && issue_en[1])
                         || (from_dec[0] && dec_idx[0] && issue_en[0]);
    assign dec_issued[0] = from_dec[0] && !dec_idx[0] && issue_en[0];

    assign enq        = in_valid & ~dec_issued;
    assign n_enq      = {1'b0, enq[1]} + {1'b0, enq[0]};
    assign wr_ptr[1]  = tail;
    assign wr_ptr[0]  = tail + queue_ptr_t'(enq[1]);
    assign count_next = count - queue_cnt_t'(q_take) + queue_cnt_t'(n_enq);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            stall <= 1'b0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            stall <= 1'b0;
        end else begin
            head  <= head + queue_ptr_t'(q_take);
            tail  <= tail + queue_ptr_t'(n_enq);
            count <= count_next;
            // leave room for a full pair before the next edge
            stall <= (count_next > queue_cnt_t'(DEPTH - 2));
        end
    end

    always_ff @(posedge clk) begin
        if (!flush) begin
            for (int i = 0; i < 2; i++) begin
                if (enq[i]) begin
                    q_op[wr_ptr[i]]       <= dec_op[i];
                    q_rdst[wr_ptr[i]]     <= dec_rdst[i];
                    q_regwrite[wr_ptr[i]] <= dec_regwrite[i];
                    q_ra1[wr_ptr[i]]      <= dec_ra1[i];
                    q_ra2[wr_ptr[i]]      <= dec_ra2[i];
                    q_imm[wr_ptr[i]]      <= dec_imm[i];
                    q_pc[wr_ptr[i]]       <= dec_pc[i];
                end
            end
        end
    end

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic [1:0]           dec_valid,
    input  issue_pkg::issue_op_t dec_op [1:0],
    input  issue_pkg::reg_addr_t dec_rdst [1:0],
    input  logic [1:0]           dec_regwrite,
    input  issue_pkg::reg_addr_t dec_ra1 [1:0],
    input  issue_pkg::reg_addr_t dec_ra2 [1:0],
    input  issue_pkg::imm_t      dec_imm [1:0],
    input  issue_pkg::data_t     dec_pc [1:0],
    input  logic [1:0]           operand_ready,
    input  logic [1:0]           wb_en,
    input  issue_pkg::reg_addr_t wb_addr [1:0],
    input  issue_pkg::data_t     wb_data [1:0],
    output logic                 stall,
    output issue_pkg::reg_addr_t cand_ra1 [1:0],
    output issue_pkg::reg_addr_t cand_ra2 [1:0],
    output logic [1:0]           hi_read,
    output logic [1:0]           lo_read,
    output logic [1:0]           cp0_read,
    output logic [1:0]           iss_valid,
    output issue_pkg::issue_op_t iss_op [1:0],
    output issue_pkg::reg_addr_t iss_rdst [1:0],
    output logic [1:0]           iss_regwrite,
    output issue_pkg::data_t     iss_pc [1:0],
    output issue_pkg::imm_t      iss_imm [1:0],
    output issue_pkg::data_t     iss_rd1 [1:0],
    output issue_pkg::data_t     iss_rd2 [1:0]
);

    import issue_pkg::*;

    logic [1:0] cand_valid;
    issue_op_t  cand_op [1:0];
    reg_addr_t  cand_rdst [1:0];
    logic [1:0] cand_regwrite;
    imm_t       cand_imm [1:0];
    data_t      cand_pc [1:0];
    logic [1:0] issue_en;
    reg_addr_t  rd_addr [3:0];
    data_t      rd_data [3:0];

    issue_queue u_issue_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_rdst      (dec_rdst),
        .dec_regwrite  (dec_regwrite),
        .dec_ra1       (dec_ra1),
        .dec_ra2       (dec_ra2),
        .dec_imm       (dec_imm),
        .dec_pc        (dec_pc),
        .operand_ready (operand_ready),
        .stall         (stall),
        .cand_valid    (cand_valid),
        .cand_op       (cand_op),
        .cand_rdst     (cand_rdst),
        .cand_regwrite (cand_regwrite),
        .cand_ra1      (cand_ra1),
        .cand_ra2      (cand_ra2),
        .cand_imm      (cand_imm),
        .cand_pc       (cand_pc),
        .issue_en      (issue_en)
    );

    // read ports 3/2 serve the older candidate, 1/0 the younger
    assign rd_addr[3] = cand_ra1[1];
    assign rd_addr[2] = cand_ra2[1];
    assign rd_addr[1] = cand_ra1[0];
    assign rd_addr[0] = cand_ra2[0];

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            // flags for the bypass network's hi/lo/cp0 lookups
            hi_read[k]  = cand_valid[k] && (cand_op[k] == MFHI);
            lo_read[k]  = cand_valid[k] && (cand_op[k] == MFLO);
            cp0_read[k] = cand_valid[k] && (cand_op[k] == MFC0);

            iss_valid[k]    = issue_en[k];
            iss_op[k]       = issue_en[k] ? cand_op[k] : ALU;
            iss_rdst[k]     = issue_en[k] ? cand_rdst[k] : '0;
            iss_regwrite[k] = issue_en[k] && cand_regwrite[k];
            iss_pc[k]       = issue_en[k] ? cand_pc[k] : '0;
            iss_imm[k]      = issue_en[k] ? cand_imm[k] : '0;
            iss_rd1[k]      = issue_en[k] ? rd_data[2*k+1] : '0;
            iss_rd2[k]      = issue_en[k] ? rd_data[2*k] : '0;
        end
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== dv/issue_stage_tb.sv ====
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_stage_tb;

    import issue_pkg::*;

    typedef struct packed {
        issue_op_t op;
        reg_addr_t rdst;
        logic      rw;
        reg_addr_t ra1;
        reg_addr_t ra2;
        imm_t      imm;
        data_t     pc;
    } instr_t;

    localparam int DEPTH = `ISSUE_QUEUE_DEPTH;
    localparam int RAND_LEN = 400;
    // reset, reset test, direct, pairing, queue fill and drain, flush, random, margin
    localparam int CYCLE_LIMIT = 10 + 4 + 10 + 6 + 43 + 35 + RAND_LEN + 100;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic [1:0] dec_valid;
    issue_op_t  dec_op [1:0];
    reg_addr_t  dec_rdst [1:0];
    logic [1:0] dec_regwrite;
    reg_addr_t  dec_ra1 [1:0];
    reg_addr_t  dec_ra2 [1:0];
    imm_t       dec_imm [1:0];
    data_t      dec_pc [1:0];
    logic [1:0] operand_ready;
    logic [1:0] wb_en;
    reg_addr_t  wb_addr [1:0];
    data_t      wb_data [1:0];
    logic       stall;
    reg_addr_t  cand_ra1 [1:0];
    reg_addr_t  cand_ra2 [1:0];
    logic [1:0] hi_read;
    logic [1:0] lo_read;
    logic [1:0] cp0_read;
    logic [1:0] iss_valid;
    issue_op_t  iss_op [1:0];
    reg_addr_t  iss_rdst [1:0];
    logic [1:0] iss_regwrite;
    data_t      iss_pc [1:0];
    imm_t       iss_imm [1:0];
    data_t      iss_rd1 [1:0];
    data_t      iss_rd2 [1:0];

    // reference model state
    instr_t     wait_q [$];
    instr_t     pend [1:0];
    data_t      shadow [`REG_COUNT];
    logic       m_stall;
    logic       pair_taken;
    logic       saw_stall;
    logic [1:0] last_iss;
    data_t      next_pc;
    data_t      flush_floor;

    integer seed;
    string  test_name;
    int     test_errors;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycles = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_stage UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_rdst      (dec_rdst),
        .dec_regwrite  (dec_regwrite),
        .dec_ra1       (dec_ra1),
        .dec_ra2       (dec_ra2),
        .dec_imm       (dec_imm),
        .dec_pc        (dec_pc),
        .operand_ready (operand_ready),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .stall         (stall),
        .cand_ra1      (cand_ra1),
        .cand_ra2      (cand_ra2),
        .hi_read       (hi_read),
        .lo_read       (lo_read),
        .cp0_read      (cp0_read),
        .iss_valid     (iss_valid),
        .iss_op        (iss_op),
        .iss_rdst      (iss_rdst),
        .iss_regwrite  (iss_regwrite),
        .iss_pc        (iss_pc),
        .iss_imm       (iss_imm),
        .iss_rd1       (iss_rd1),
        .iss_rd2       (iss_rd2)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, sig, exp, act);
            test_errors++;
        end
    endtask

    function automatic instr_t make_instr(input issue_op_t op, input reg_addr_t rdst,
                                          input logic rw, input reg_addr_t ra1,
                                          input reg_addr_t ra2);
        instr_t ins;
        ins.op   = op;
        ins.rdst = rdst;
        ins.rw   = rw;
        ins.ra1  = ra1;
        ins.ra2  = ra2;
        ins.imm  = 16'($random(seed));
        ins.pc   = next_pc;
        next_pc  = next_pc + 32'd4;
        return ins;
    endfunction

    // few registers so hazards show up often
    function automatic instr_t rand_instr();
        issue_op_t op;
        reg_addr_t rdst;
        logic      rw;
        reg_addr_t ra1;
        reg_addr_t ra2;
        op   = issue_op_t'(4'({$random(seed)} % 12));
        rdst = 5'({$random(seed)} % 8);
        rw   = 1'($random(seed));
        ra1  = 5'({$random(seed)} % 8);
        ra2  = 5'({$random(seed)} % 8);
        return make_instr(op, rdst, rw, ra1, ra2);
    endfunction

    function automatic logic pairable(input instr_t older, input instr_t younger);
        logic raw;
        logic md_old;
        logic md_young;
        raw = older.rw && (older.rdst != '0)
              && ((older.rdst == younger.ra1) || (older.rdst == younger.ra2));
        md_old = older.op inside {MULT, MULTU, DIV, DIVU};
        md_young = younger.op inside {MULT, MULTU, DIV, DIVU};
        return !(raw || (md_old && md_young) || (older.op == MTC0 && younger.op == MTC0));
    endfunction

    task automatic present(input logic [1:0] v, input instr_t older, input instr_t younger);
        pend[1] = older;
        pend[0] = younger;
        dec_valid = v;
        for (int k = 0; k < 2; k++) begin
            dec_op[k]       = pend[k].op;
            dec_rdst[k]     = pend[k].rdst;
            dec_regwrite[k] = pend[k].rw;
            dec_ra1[k]      = pend[k].ra1;
            dec_ra2[k]      = pend[k].ra2;
            dec_imm[k]      = pend[k].imm;
            dec_pc[k]       = pend[k].pc;
        end
    endtask

    // a pair that was not taken yet stays on the inputs
    task automatic offer_pair(input logic [1:0] v);
        instr_t older;
        instr_t younger;
        if (pair_taken) begin
            older = rand_instr();
            younger = rand_instr();
            present(v, older, younger);
        end
    endtask

    task automatic rand_wb();
        for (int k = 0; k < 2; k++) begin
            wb_en[k]   = 1'($random(seed));
            wb_addr[k] = 5'({$random(seed)} % 8);
            wb_data[k] = $random(seed);
        end
    endtask

    task automatic no_wb();
        wb_en = 2'b00;
        for (int k = 0; k < 2; k++) begin
            wb_addr[k] = '0;
            wb_data[k] = '0;
        end
    endtask

    // check mid cycle, then advance the model to the next edge
    task automatic step();
        instr_t     all [$];
        instr_t     c [1:0];
        logic [1:0] cv;
        logic [1:0] exp_iss;
        #48;
        all = wait_q;
        if (!m_stall) begin
            if (dec_valid[1]) all.push_back(pend[1]);
            if (dec_valid[0]) all.push_back(pend[0]);
        end
        cv[1] = all.size() > 0;
        cv[0] = all.size() > 1;
        c[1] = cv[1] ? all[0] : '0;
        c[0] = cv[0] ? all[1] : '0;
        exp_iss[1] = cv[1] && operand_ready[1];
        exp_iss[0] = cv[0] && exp_iss[1] && operand_ready[0] && pairable(c[1], c[0]);
        last_iss = iss_valid;

        check_val("stall", 32'(m_stall), 32'(stall));
        check_val("iss_valid", 32'(exp_iss), 32'(iss_valid));
        for (int k = 1; k >= 0; k--) begin
            check_val($sformatf("hi_read[%0d]", k), 32'(cv[k] && c[k].op == MFHI),
                      32'(hi_read[k]));
            check_val($sformatf("lo_read[%0d]", k), 32'(cv[k] && c[k].op == MFLO),
                      32'(lo_read[k]));
            check_val($sformatf("cp0_read[%0d]", k), 32'(cv[k] && c[k].op == MFC0),
                      32'(cp0_read[k]));
            if (cv[k]) begin
                check_val($sformatf("cand_ra1[%0d]", k), 32'(c[k].ra1), 32'(cand_ra1[k]));
                check_val($sformatf("cand_ra2[%0d]", k), 32'(c[k].ra2), 32'(cand_ra2[k]));
            end
            if (exp_iss[k]) begin
                check_val($sformatf("iss_op[%0d]", k), 32'(c[k].op), 32'(iss_op[k]));
                check_val($sformatf("iss_rdst[%0d]", k), 32'(c[k].rdst), 32'(iss_rdst[k]));
                check_val($sformatf("iss_regwrite[%0d]", k), 32'(c[k].rw),
                          32'(iss_regwrite[k]));
                check_val($sformatf("iss_pc[%0d]", k), c[k].pc, iss_pc[k]);
                check_val($sformatf("iss_imm[%0d]", k), 32'(c[k].imm), 32'(iss_imm[k]));
                check_val($sformatf("iss_rd1[%0d]", k), shadow[c[k].ra1], iss_rd1[k]);
                check_val($sformatf("iss_rd2[%0d]", k), shadow[c[k].ra2], iss_rd2[k]);
            end
            assert (!iss_valid[k] || iss_pc[k] >= flush_floor) else begin
                $display("error in %s: slot %0d issued pc %h from before the last flush",
                         test_name, k, iss_pc[k]);
                test_errors++;
            end
        end

        if (exp_iss[1]) all.delete(0);
        if (exp_iss[0]) all.delete(0);
        pair_taken = !m_stall || flush;
        if (flush) begin
            wait_q.delete();
            m_stall = 1'b0;
            flush_floor = next_pc;
        end else begin
            wait_q = all;
            m_stall = all.size() > DEPTH - 2;
        end
        if (stall) saw_stall = 1'b1;
        // port 1 is applied last so it wins on a shared address
        for (int k = 0; k < 2; k++) begin
            if (wb_en[k] && wb_addr[k] != '0) shadow[wb_addr[k]] = wb_data[k];
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %-12s %s, %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
        errors += test_errors;
        tests_run++;
        if (test_errors != 0) tests_failed++;
    endtask

    initial begin
        instr_t a;
        instr_t b;
        seed = 64;
        next_pc = 32'h0000_1000;
        flush_floor = '0;
        m_stall = 1'b0;
        pair_taken = 1'b1;
        saw_stall = 1'b0;
        last_iss = 2'b00;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        test_name = "init";
        flush = 1'b0;
        operand_ready = 2'b00;
        present(2'b00, '0, '0);
        no_wb();
        for (int r = 0; r < `REG_COUNT; r++) shadow[r] = '0;
        @(posedge rst_n);

        start_test("reset");
        operand_ready = 2'b11;
        step();
        step();
        a = make_instr(ALU, 5'd20, 1'b1, 5'd1, 5'd2);
        b = make_instr(ALU, 5'd21, 1'b1, 5'd3, 5'd4);
        present(2'b11, a, b);
        step();
        present(2'b00, '0, '0);
        step();
        finish_test();

        start_test("direct");
        for (int i = 0; i < 4; i++) begin
            rand_wb();
            step();
        end
        no_wb();
        for (int i = 0; i < 6; i++) begin
            a = make_instr(ALU, 5'(16 + i), 1'b1, 5'(1 + i), 5'(2 + i));
            b = make_instr(LOAD, 5'd24, 1'b1, 5'(i), 5'(7 - i));
            present(2'b11, a, b);
            step();
            check_val("pair issued", 32'(2'b11), 32'(last_iss));
        end
        present(2'b00, '0, '0);
        finish_test();

        start_test("pairing");
        for (int i = 0; i < 3; i++) begin
            case (i)
                0: begin
                    a = make_instr(ALU, 5'd3, 1'b1, 5'd1, 5'd2);
                    b = make_instr(ALU, 5'd4, 1'b1, 5'd3, 5'd5);
                end
                1: begin
                    a = make_instr(MULT, 5'd0, 1'b0, 5'd1, 5'd2);
                    b = make_instr(DIVU, 5'd0, 1'b0, 5'd4, 5'd5);
                end
                default: begin
                    a = make_instr(MTC0, 5'd0, 1'b0, 5'd1, 5'd0);
                    b = make_instr(MTC0, 5'd0, 1'b0, 5'd2, 5'd0);
                end
            endcase
            present(2'b11, a, b);
            step();
            check_val("older alone", 32'(2'b10), 32'(last_iss));
            present(2'b00, '0, '0);
            step();
            check_val("younger next", 32'(2'b10), 32'(last_iss));
        end
        finish_test();

        start_test("queue_stall");
        operand_ready = 2'b00;
        saw_stall = 1'b0;
        for (int i = 0; i < 12; i++) begin
            offer_pair(2'b11);
            rand_wb();
            step();
        end
        assert (saw_stall) else begin
            $display("error in %s: stall never rose while the queue filled", test_name);
            test_errors++;
        end
        operand_ready = 2'b11;
        for (int i = 0; i < 30 && (wait_q.size() != 0 || !pair_taken); i++) begin
            offer_pair(2'b00);
            rand_wb();
            step();
        end
        present(2'b00, '0, '0);
        step();
        check_val("left in queue", 32'd0, 32'(last_iss));
        finish_test();

        start_test("flush");
        operand_ready = 2'b00;
        no_wb();
        for (int i = 0; i < 4; i++) begin
            offer_pair(2'b11);
            step();
        end
        flush = 1'b1;
        offer_pair(2'b11);
        step();
        flush = 1'b0;
        operand_ready = 2'b11;
        for (int i = 0; i < 10; i++) begin
            offer_pair(2'b11);
            step();
        end
        for (int i = 0; i < 20 && wait_q.size() != 0; i++) begin
            offer_pair(2'b00);
            step();
        end
        finish_test();

        start_test("random");
        for (int i = 0; i < RAND_LEN; i++) begin
            flush = ({$random(seed)} % 32) == 0;
            operand_ready[1] = ({$random(seed)} % 4) != 0;
            operand_ready[0] = ({$random(seed)} % 4) != 0;
            rand_wb();
            case ({$random(seed)} % 4)
                0: offer_pair(2'b00);
                1: offer_pair(2'b10);
                default: offer_pair(2'b11);
            endcase
            step();
        end
        flush = 1'b0;
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/reg_file.sv
rtl/pair_check.sv
rtl/issue_queue.sv
rtl/issue_stage.sv
dv/tb_clock_gen.sv
dv/issue_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module issue_stage_tb \
    -f list.f -o issue_stage_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/issue_stage_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Done: no errors" && exit 0 || exit 1
